//--- filelist.f
+incdir+.
kv_pkg.sv
kv_if.sv
kv_fsm.sv
kv_client.sv
key_vault.sv
keyed_mix_engine.sv
kv_subsys_top.sv
kv_properties.sv
kv_tb.sv

//--- kv_tb.sv
`timescale 1ns/1ps

module kv_tb import kv_pkg::*; ();

   localparam int WD_CYCLES = 6 * 8 * 60;

   logic       clk;
   logic       rst_n;
   logic       key_sel_en;
   logic       src_sel_en;
   logic       dest_sel_en;
   kv_entry_t  key_sel;
   kv_entry_t  src_sel;
   kv_entry_t  dest_sel;
   logic       host_wr_en;
   kv_entry_t  host_entry;
   kv_offset_t host_offset;
   kv_dword_t  host_wdata;
   kv_entry_t  host_rd_entry;
   kv_offset_t host_rd_offset;
   kv_dword_t  host_rdata;
   logic       key_done;
   logic       src_done;
   logic       dest_done;

   logic [7:0][31:0] model [8];
   logic [31:0]      lfsr_q = 32'h78bd6225;
   logic [31:0]      exp_rd;
   logic             rd_chk = 1'b0;
   int key_cnt = 0;
   int src_cnt = 0;
   int dest_cnt = 0;
   int errors = 0;
   int checks = 0;
   int failed_tests = 0;

   kv_subsys_top UUT (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
   endtask

   // expected entry with word i as (key ^ src) rotated left by i+1
   function automatic logic [7:0][31:0] mix_ref(input logic [7:0][31:0] k,
                                               input logic [7:0][31:0] s);
      logic [7:0][31:0] r;
      logic [31:0]      x;
      for (int i = 0; i < 8; i++) begin
         x = k[i] ^ s[i];
         r[i] = (x << (i + 1)) | (x >> (31 - i));
      end
      return r;
   endfunction

   // done pulse counters
   always @(negedge clk) begin
      if (rst_n) begin
         if (key_done) key_cnt++;
         if (src_done) src_cnt++;
         if (dest_done) dest_cnt++;
      end
   end

   always @(negedge clk) begin
      if (rd_chk) begin
         checks++;
         assert (host_rdata === exp_rd) else begin
            errors++;
            $display("[ERROR] %0d ns: entry %0d dword %0d read %h, expected %h", $time,
                     host_rd_entry, host_rd_offset, host_rdata, exp_rd);
         end
      end
   end

   task automatic check_count(input string what, input int got, input int exp);
      assert (got == exp) else begin
         errors++;
         $display("[ERROR] %0d ns: %s count %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_vault();
      for (int e = 0; e < 8; e++) begin
         for (int o = 0; o < 8; o++) begin
            @(posedge clk);
            #5;
            host_rd_entry = kv_entry_t'(e);
            host_rd_offset = kv_offset_t'(o);
            exp_rd = model[e][o];
            rd_chk = 1'b1;
         end
      end
      @(posedge clk);
      #5;
      rd_chk = 1'b0;
   endtask

   task automatic fill_vault();
      logic [31:0] v;
      for (int e = 0; e < 8; e++) begin
         for (int o = 0; o < 8; o++) begin
            rand_bits(32, v);
            @(posedge clk);
            #5;
            host_wr_en = 1'b1;
            host_entry = kv_entry_t'(e);
            host_offset = kv_offset_t'(o);
            host_wdata = v;
            model[e][o] = v;
         end
      end
      @(posedge clk);
      #5;
      host_wr_en = 1'b0;
   endtask

   task automatic run_op(input kv_entry_t k, input kv_entry_t s, input kv_entry_t d,
                         input logic den);
      logic [7:0][31:0] exp;
      int kc;
      int sc;
      int dc;
      int n;
      exp = mix_ref(model[k], model[s]);
      kc = key_cnt;
      sc = src_cnt;
      dc = dest_cnt;
      n = 0;
      @(posedge clk);
      #5;
      key_sel = k;
      src_sel = s;
      dest_sel = d;
      dest_sel_en = den;
      key_sel_en = 1'b1;
      src_sel_en = 1'b1;
      @(posedge clk);
      #5;
      key_sel_en = 1'b0;
      src_sel_en = 1'b0;
      if (den) begin
         while (dest_cnt == dc && n < 60) begin
            @(posedge clk);
            n++;
         end
         assert (dest_cnt != dc) else begin
            errors++;
            $display("dest_done never arrived for entry %0d within 60 cycles", d);
         end
         model[d] = exp;
      end else begin
         // long enough for a writeback to show up
         repeat (60) @(posedge clk);
      end
      check_count("key_done", key_cnt, kc + 1);
      check_count("src_done", src_cnt, sc + 1);
      check_count("dest_done", dest_cnt, dc + int'(den));
      #5;
      dest_sel_en = 1'b0;
   endtask

   task automatic end_test(input int num, input string name, input int err_before);
      if (errors == err_before) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         failed_tests++;
         $display("test %0d %s: %0d errors", num, name, errors - err_before);
      end
   endtask

   initial begin
      #(WD_CYCLES * 100);
      $display("watchdog expired before the tests finished");
      $display("sim failed");
      $finish;
   end

   initial begin
      logic [31:0] v;
      kv_entry_t   k;
      kv_entry_t   s;
      kv_entry_t   d;
      int          err0;
      int          total;
      rst_n = 1'b0;
      key_sel_en = 1'b0;
      src_sel_en = 1'b0;
      dest_sel_en = 1'b0;
      key_sel = '0;
      src_sel = '0;
      dest_sel = '0;
      host_wr_en = 1'b0;
      host_entry = '0;
      host_offset = '0;
      host_wdata = '0;
      host_rd_entry = '0;
      host_rd_offset = '0;
      exp_rd = '0;
      for (int e = 0; e < 8; e++) model[e] = '0;
      repeat (8) @(posedge clk);
      #5;
      rst_n = 1'b1;

      err0 = errors;
      check_vault();
      check_count("key_done", key_cnt, 0);
      check_count("src_done", src_cnt, 0);
      check_count("dest_done", dest_cnt, 0);
      end_test(1, "reset state", err0);

      err0 = errors;
      fill_vault();
      check_vault();
      end_test(2, "host write and read", err0);

      err0 = errors;
      rand_bits(9, v);
      run_op(v[2:0], v[5:3], v[8:6], 1'b1);
      check_vault();
      end_test(3, "single operation", err0);

      // each dest feeds the source of the next operation
      err0 = errors;
      rand_bits(3, v);
      d = v[2:0];
      for (int i = 0; i < 8; i++) begin
         s = d;
         rand_bits(6, v);
         k = v[2:0];
         d = v[5:3];
         run_op(k, s, d, 1'b1);
         check_vault();
      end
      end_test(4, "chained operations", err0);

      err0 = errors;
      rand_bits(9, v);
      run_op(v[2:0], v[5:3], v[8:6], 1'b0);
      check_vault();
      end_test(5, "dest disabled", err0);

      err0 = errors;
      rand_bits(9, v);
      run_op(v[2:0], v[2:0], v[5:3], 1'b1);
      check_vault();
      run_op(v[8:6], v[5:3], v[5:3], 1'b1);
      check_vault();
      end_test(6, "overlapping entries", err0);

      total = errors + UUT.u_props.fail_cnt;
      $display("tests 6, failed tests %0d, read checks %0d, errors %0d, assertion fails %0d",
               failed_tests, checks, errors, UUT.u_props.fail_cnt);
      if (total == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- kv_properties.sv
`timescale 1ns/1ps

module kv_properties (
   input logic clk,
   input logic rst_n,
   input logic dest_sel_en,
   input logic dest_wr_vld,
   input logic key_done,
   input logic src_done,
   input logic dest_done
);

   int fail_cnt = 0;

   // every done is a single cycle pulse
   key_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      key_done |=> !key_done)
      else begin
         fail_cnt++;
         $error("key_done high for more than one cycle");
      end

   src_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      src_done |=> !src_done)
      else begin
         fail_cnt++;
         $error("src_done high for more than one cycle");
      end

   dest_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      dest_done |=> !dest_done)
      else begin
         fail_cnt++;
         $error("dest_done high for more than one cycle");
      end

   // writeback only when the dest select is enabled
   no_write_disabled: assert property (@(posedge clk) disable iff (!rst_n)
      !dest_sel_en |-> !dest_wr_vld)
      else begin
         fail_cnt++;
         $error("vault write while dest_sel_en is low");
      end

   quiet_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> !key_done && !src_done && !dest_done)
      else begin
         fail_cnt++;
         $error("done output high right after reset");
      end

endmodule

bind kv_subsys_top kv_properties u_props (
   .clk         (clk),
   .rst_n       (rst_n),
   .dest_sel_en (dest_sel_en),
   .dest_wr_vld (wr_if.dest_wr_vld),
   .key_done    (key_done),
   .src_done    (src_done),
   .dest_done   (dest_done)
);

//--- kv_subsys_top.sv
`timescale 1ns/1ps

module kv_subsys_top import kv_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       key_sel_en,
   input  logic       src_sel_en,
   input  logic       dest_sel_en,
   input  kv_entry_t  key_sel,
   input  kv_entry_t  src_sel,
   input  kv_entry_t  dest_sel,
   input  logic       host_wr_en,
   input  kv_entry_t  host_entry,
   input  kv_offset_t host_offset,
   input  kv_dword_t  host_wdata,
   input  kv_entry_t  host_rd_entry,
   input  kv_offset_t host_rd_offset,
   output kv_dword_t  host_rdata,
   output logic       key_done,
   output logic       src_done,
   output logic       dest_done
);

   kv_rd_if     rd_if ();
   kv_wr_if     wr_if ();
   kv_engine_if eng_if ();

   key_vault u_key_vault (
      .clk            (clk),
      .rst_n          (rst_n),
      .rd             (rd_if.vault),
      .wr             (wr_if.vault),
      .host_wr_en     (host_wr_en),
      .host_entry     (host_entry),
      .host_offset    (host_offset),
      .host_wdata     (host_wdata),
      .host_rd_entry  (host_rd_entry),
      .host_rd_offset (host_rd_offset),
      .host_rdata     (host_rdata)
   );

   kv_client u_kv_client (
      .clk         (clk),
      .rst_n       (rst_n),
      .key_sel_en  (key_sel_en),
      .src_sel_en  (src_sel_en),
      .dest_sel_en (dest_sel_en),
      .key_sel     (key_sel),
      .src_sel     (src_sel),
      .dest_sel    (dest_sel),
      .rd          (rd_if.client),
      .wr          (wr_if.client),
      .eng         (eng_if.client)
   );

   keyed_mix_engine u_engine (
      .clk   (clk),
      .rst_n (rst_n),
      .eng   (eng_if.engine)
   );

   assign key_done  = eng_if.key_done;
   assign src_done  = eng_if.src_done;
   assign dest_done = eng_if.dest_done;

endmodule

//--- keyed_mix_engine.sv
`timescale 1ns/1ps
`include "kv_config.svh"

module keyed_mix_engine import kv_pkg::*; (
   input logic         clk,
   input logic         rst_n,
   kv_engine_if.engine eng
);

   kv_dword_t  key_q [`KV_ENTRY_DWORDS];
   kv_dword_t  src_q [`KV_ENTRY_DWORDS];
   logic       key_seen;
   logic       src_seen;
   logic       start_calc;
   mix_state_e state;
   kv_offset_t idx;
   kv_offset_t rev_idx;

   // (key ^ src) rotated left by i+1
   function automatic kv_dword_t mix_word(kv_dword_t k, kv_dword_t s, kv_offset_t i);
      kv_dword_t   x;
      int unsigned sh;
      x  = k ^ s;
      sh = int'(i) + 1;
      return (x << sh) | (x >> (`KV_DWORD_W - sh));
   endfunction

   // key and source word store
   always_ff @(posedge clk) begin
      if (eng.key_write_en) begin
         key_q[eng.key_write_offset] <= eng.key_write_data;
      end
      if (eng.src_write_en) begin
         src_q[eng.src_write_offset] <= eng.src_write_data;
      end
   end

   assign start_calc = (state == LOAD) && key_seen && src_seen;

   // sticky done flags, a new done on the clearing edge still counts
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         key_seen <= 1'b0;
         src_seen <= 1'b0;
      end else begin
         key_seen <= eng.key_done | (key_seen & ~start_calc);
         src_seen <= eng.src_done | (src_seen & ~start_calc);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= LOAD;
         idx   <= '0;
      end else begin
         case (state)
            LOAD: begin
               if (start_calc) begin
                  state <= CALC;
                  idx   <= '0;
               end
            end
            CALC: begin
               if (idx == kv_offset_t'(`KV_ENTRY_DWORDS - 1)) begin
                  state <= AVAIL;
               end else begin
                  idx <= idx + 1'b1;
               end
            end
            AVAIL: begin
               // wait for the writeback unless nothing goes to the vault
               if (!eng.dest_keyvault || eng.dest_done) begin
                  state <= LOAD;
               end
            end
            default: state <= LOAD;
         endcase
      end
   end

   assign rev_idx = kv_offset_t'(`KV_ENTRY_DWORDS - 1) - idx;

   // one result word per CALC cycle, stored reversed
   always_ff @(posedge clk) begin
      if (state == CALC) begin
         eng.dest_data[rev_idx] <= mix_word(key_q[idx], src_q[idx], idx);
      end
   end

   assign eng.dest_data_avail = (state == AVAIL);

endmodule

//--- key_vault.sv
`timescale 1ns/1ps
`include "kv_config.svh"

module key_vault import kv_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   kv_rd_if.vault     rd,
   kv_wr_if.vault     wr,
   input  logic       host_wr_en,
   input  kv_entry_t  host_entry,
   input  kv_offset_t host_offset,
   input  kv_dword_t  host_wdata,
   input  kv_entry_t  host_rd_entry,
   input  kv_offset_t host_rd_offset,
   output kv_dword_t  host_rdata
);

   kv_dword_t mem [`KV_NUM_ENTRIES][`KV_ENTRY_DWORDS];

   // client writeback wins over the host
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int e = 0; e < `KV_NUM_ENTRIES; e++) begin
            for (int d = 0; d < `KV_ENTRY_DWORDS; d++) begin
               mem[e][d] <= '0;
            end
         end
      end else if (wr.dest_wr_vld) begin
         mem[wr.dest_entry][wr.dest_offset] <= wr.dest_data;
      end else if (host_wr_en) begin
         mem[host_entry][host_offset] <= host_wdata;
      end
   end

   // two client read ports, one cycle latency
   always_ff @(posedge clk) begin
      rd.key_data <= mem[rd.key_entry][rd.key_offset];
      rd.src_data <= mem[rd.src_entry][rd.src_offset];
   end

   // host side peeks without latency
   assign host_rdata = mem[host_rd_entry][host_rd_offset];

endmodule

//--- kv_client.sv
`timescale 1ns/1ps
`include "kv_config.svh"

module kv_client import kv_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      key_sel_en,
   input  logic      src_sel_en,
   input  logic      dest_sel_en,
   input  kv_entry_t key_sel,
   input  kv_entry_t src_sel,
   input  kv_entry_t dest_sel,
   kv_rd_if.client     rd,
   kv_wr_if.client     wr,
   kv_engine_if.client eng
);

   kv_offset_t key_read_offset;
   kv_offset_t src_read_offset;
   kv_offset_t dest_write_offset;
   logic       dest_write_en;
   logic       dest_start;
   logic       avail_q;

   // key read
   kv_fsm key_read_fsm (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (key_sel_en),
      .read_offset  (key_read_offset),
      .write_en     (eng.key_write_en),
      .write_offset (eng.key_write_offset),
      .done         (eng.key_done)
   );

   assign rd.key_entry       = key_sel;
   assign rd.key_offset      = key_read_offset;
   assign eng.key_write_data = rd.key_data;

   // source read
   kv_fsm src_read_fsm (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (src_sel_en),
      .read_offset  (src_read_offset),
      .write_en     (eng.src_write_en),
      .write_offset (eng.src_write_offset),
      .done         (eng.src_done)
   );

   assign rd.src_entry       = src_sel;
   assign rd.src_offset      = src_read_offset;
   assign eng.src_write_data = rd.src_data;

   // kick the writeback once per result
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         avail_q <= 1'b0;
      end else begin
         avail_q <= eng.dest_data_avail;
      end
   end

   assign dest_start = eng.dest_data_avail & ~avail_q & dest_sel_en;

   // result already sits in the engine register, no read offset needed
   kv_fsm dest_write_fsm (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (dest_start),
      .read_offset  (),
      .write_en     (dest_write_en),
      .write_offset (dest_write_offset),
      .done         (eng.dest_done)
   );

   assign eng.dest_keyvault = dest_sel_en;

   // engine stores word i at 7-i, so undo the reversal here
   assign wr.dest_wr_vld = dest_write_en;
   assign wr.dest_entry  = dest_sel;
   assign wr.dest_offset = dest_write_offset;
   assign wr.dest_data   =
      eng.dest_data[kv_offset_t'(`KV_ENTRY_DWORDS - 1) - dest_write_offset];

endmodule

//--- kv_fsm.sv
`timescale 1ns/1ps
`include "kv_config.svh"

module kv_fsm import kv_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       start,
   output kv_offset_t read_offset,
   output logic       write_en,
   output kv_offset_t write_offset,
   output logic       done
);

   kv_fsm_state_e state;
   kv_offset_t    cnt;
   logic          last_cnt;

   assign last_cnt = (cnt == kv_offset_t'(`KV_ENTRY_DWORDS - 1));

   // start is only honoured from IDLE
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  state <= RUN;
                  cnt   <= '0;
               end
            end
            RUN: begin
               if (last_cnt) begin
                  state <= LAST;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            // last write in flight
            LAST: state <= DONE;
            DONE: state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   assign read_offset = cnt;

   // write trails the read by the vault read latency
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         write_en     <= 1'b0;
         write_offset <= '0;
      end else begin
         write_en     <= (state == RUN);
         write_offset <= cnt;
      end
   end

   // one cycle, straight from the state register
   assign done = (state == DONE);

endmodule

//--- kv_if.sv
`timescale 1ns/1ps
`include "kv_config.svh"

// client read addressing into the vault, data comes back one cycle later
interface kv_rd_if import kv_pkg::*; ();
   kv_entry_t  key_entry;
   kv_offset_t key_offset;
   kv_entry_t  src_entry;
   kv_offset_t src_offset;
   kv_dword_t  key_data;
   kv_dword_t  src_data;

   modport client (output key_entry, key_offset, src_entry, src_offset,
                   input key_data, src_data);
   modport vault (input key_entry, key_offset, src_entry, src_offset,
                  output key_data, src_data);
endinterface

// result writeback into the vault
interface kv_wr_if import kv_pkg::*; ();
   logic       dest_wr_vld;
   kv_entry_t  dest_entry;
   kv_offset_t dest_offset;
   kv_dword_t  dest_data;

   modport client (output dest_wr_vld, dest_entry, dest_offset, dest_data);
   modport vault (input dest_wr_vld, dest_entry, dest_offset, dest_data);
endinterface

// client to crypto engine
interface kv_engine_if import kv_pkg::*; ();
   logic       key_write_en;
   kv_offset_t key_write_offset;
   kv_dword_t  key_write_data;
   logic       src_write_en;
   kv_offset_t src_write_offset;
   kv_dword_t  src_write_data;
   logic       key_done;
   logic       src_done;
   logic       dest_keyvault;
   logic       dest_done;
   logic       dest_data_avail;
   kv_dword_t [`KV_ENTRY_DWORDS-1:0] dest_data;

   modport client (output key_write_en, key_write_offset, key_write_data,
                   output src_write_en, src_write_offset, src_write_data,
                   output key_done, src_done, dest_keyvault, dest_done,
                   input dest_data_avail, dest_data);
   modport engine (input key_write_en, key_write_offset, key_write_data,
                   input src_write_en, src_write_offset, src_write_data,
                   input key_done, src_done, dest_keyvault, dest_done,
                   output dest_data_avail, dest_data);
endinterface

//--- kv_pkg.sv
`include "kv_config.svh"

package kv_pkg;

   // one data word of a vault entry
   typedef logic [`KV_DWORD_W-1:0] kv_dword_t;

   // vault entry index
   typedef logic [`KV_ENTRY_W-1:0] kv_entry_t;

   // dword offset inside an entry
   typedef logic [`KV_OFFSET_W-1:0] kv_offset_t;

   // dword sequencer states
   typedef enum logic [1:0] {
      IDLE,
      RUN,
      LAST,
      DONE
   } kv_fsm_state_e;

   // mixing engine states
   typedef enum logic [1:0] {
      LOAD,
      CALC,
      AVAIL
   } mix_state_e;

endpackage

//--- kv_config.svh
`ifndef KV_CONFIG_SVH
`define KV_CONFIG_SVH

// vault geometry
`define KV_NUM_ENTRIES 8
`define KV_ENTRY_DWORDS 8

// index widths
`define KV_ENTRY_W 3
`define KV_OFFSET_W 3

// data word width
`define KV_DWORD_W 32

`endif
